// File: rs5_pkg.sv
/* Word-only RV32I subset, no CSRs, no exceptions, no compressed code
   Unsupported encodings are mapped to OP_NOP by the decoder */
package rs5_pkg;

    // Datapath sizing
    localparam int XLEN      = 32;
    localparam int REG_COUNT = 32;

    typedef logic [XLEN-1:0]              word_t;
    typedef logic [$clog2(REG_COUNT)-1:0] reg_addr_t;
    typedef logic [3:0]                   byte_en_t;

    // First fetch after reset
    localparam word_t RESET_ADDR = 32'h0000_0000;

    // Major opcodes, instruction bits 6 to 0
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // Operations carried from decode to execute
    typedef enum logic [4:0] {
        OP_NOP,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_SLTU,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_LUI,
        OP_LW,
        OP_SW,
        OP_BEQ,
        OP_BNE,
        OP_JAL
    } op_e;

endpackage

// File: rs5_regbank.sv
/* Flip-flop bank of x1 to x31, x0 reads as zero
   Same-cycle write is forwarded to both read ports */
module rs5_regbank (
    input  logic               clk,
    input  logic               rst_i,
    input  rs5_pkg::reg_addr_t rs1_i,
    input  rs5_pkg::reg_addr_t rs2_i,
    input  rs5_pkg::reg_addr_t rd_i,
    input  logic               write_i,
    input  rs5_pkg::word_t     data_i,
    output rs5_pkg::word_t     data1_o,
    output rs5_pkg::word_t     data2_o
);
    import rs5_pkg::*;

    word_t regs [1:REG_COUNT-1];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 1; i < REG_COUNT; i++)
                regs[i] <= '0;
        end
        else if (write_i && rd_i != '0) begin
            regs[rd_i] <= data_i;
        end
    end

    // Write-through bypass
    assign data1_o = (rs1_i == '0) ? '0 : (write_i && rd_i == rs1_i) ? data_i : regs[rs1_i];
    assign data2_o = (rs2_i == '0) ? '0 : (write_i && rd_i == rs2_i) ? data_i : regs[rs2_i];

    // Decode clears the write flag for x0 destinations
    assert property (@(posedge clk) disable iff (rst_i) write_i |-> rd_i != '0)
        else $error("register write aimed at x0");

endmodule

// File: rs5_fetch.sv
/* Instruction memory must answer one clock after each unstalled edge
   Jump targets are expected to be word-aligned */
module rs5_fetch (
    input  logic           clk,
    input  logic           rst_i,
    input  logic           stall_i,
    input  logic           hazard_i,
    input  logic           jump_i,
    input  rs5_pkg::word_t jump_target_i,
    input  rs5_pkg::word_t instruction_i,
    output rs5_pkg::word_t instruction_address_o,
    output rs5_pkg::word_t instruction_o,
    output rs5_pkg::word_t pc_o,
    output logic           valid_o
);
    import rs5_pkg::*;

    // Address presented to memory this cycle
    word_t pc;

    // Replay the decode address on a hazard
    // so the memory hands back the held word next cycle
    assign instruction_address_o = hazard_i ? pc_o : pc;

    // Memory already adds the fetch cycle
    assign instruction_o = instruction_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc      <= RESET_ADDR;
            pc_o    <= RESET_ADDR;
            valid_o <= 1'b0;
        end
        else if (!stall_i) begin
            if (jump_i) begin
                // Word in flight is wrong path
                pc      <= jump_target_i;
                valid_o <= 1'b0;
            end
            else if (!hazard_i) begin
                pc_o    <= pc;
                valid_o <= 1'b1;
                pc      <= pc + 32'd4;
            end
        end
    end

    // Only word fetches exist in this core
    assert property (@(posedge clk) disable iff (rst_i)
        instruction_address_o[1:0] == 2'b00)
        else $error("fetch address not word-aligned");

endmodule

// File: rs5_decode.sv
/* Hazard check covers only the instruction in execute
   Retire results reach decode through the register bank bypass */
module rs5_decode (
    input  logic               clk,
    input  logic               rst_i,
    input  logic               stall_i,
    input  logic               jump_i,
    input  rs5_pkg::word_t     instruction_i,
    input  rs5_pkg::word_t     pc_i,
    input  logic               valid_i,
    input  rs5_pkg::word_t     rs1_data_i,
    input  rs5_pkg::word_t     rs2_data_i,
    output rs5_pkg::reg_addr_t rs1_o,
    output rs5_pkg::reg_addr_t rs2_o,
    output logic               hazard_o,
    output rs5_pkg::op_e       op_o,
    output rs5_pkg::word_t     first_operand_o,
    output rs5_pkg::word_t     second_operand_o,
    output rs5_pkg::word_t     store_data_o,
    output rs5_pkg::word_t     pc_o,
    output rs5_pkg::word_t     imm_o,
    output rs5_pkg::reg_addr_t rd_o,
    output logic               write_o,
    output logic               valid_o
);
    import rs5_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;
    reg_addr_t  rd;
    op_e        op;
    word_t      imm;
    logic       writes;
    logic       use_rs2;

    // Shared funct3 map of OP and OP-IMM
    function automatic op_e alu_op(input logic [2:0] f3, input logic sub, input logic arith);
        case (f3)
            3'b000:  return sub ? OP_SUB : OP_ADD;
            3'b001:  return OP_SLL;
            3'b010:  return OP_SLT;
            3'b011:  return OP_SLTU;
            3'b100:  return OP_XOR;
            3'b101:  return arith ? OP_SRA : OP_SRL;
            3'b110:  return OP_OR;
            default: return OP_AND;
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Field split and immediates
    //////////////////////////////////////////////////////////////////////

    assign opcode = instruction_i[6:0];
    assign funct3 = instruction_i[14:12];
    assign alt    = instruction_i[30];
    assign rd     = instruction_i[11:7];
    assign rs1_o  = instruction_i[19:15];
    assign rs2_o  = instruction_i[24:20];

    always_comb begin
        op  = OP_NOP;
        // I-type unless the format says otherwise
        imm = {{20{instruction_i[31]}}, instruction_i[31:20]};
        case (opcode)
            OPC_OP:     op = alu_op(funct3, alt, alt);
            OPC_OP_IMM: op = alu_op(funct3, 1'b0, alt);
            OPC_LUI: begin
                op  = OP_LUI;
                imm = {instruction_i[31:12], 12'b0};
            end
            OPC_LOAD: begin
                if (funct3 == 3'b010)
                    op = OP_LW;
            end
            OPC_STORE: begin
                if (funct3 == 3'b010)
                    op = OP_SW;
                imm = {{20{instruction_i[31]}}, instruction_i[31:25], instruction_i[11:7]};
            end
            OPC_BRANCH: begin
                if (funct3 == 3'b000)
                    op = OP_BEQ;
                else if (funct3 == 3'b001)
                    op = OP_BNE;
                imm = {{19{instruction_i[31]}}, instruction_i[31], instruction_i[7],
                       instruction_i[30:25], instruction_i[11:8], 1'b0};
            end
            OPC_JAL: begin
                op  = OP_JAL;
                imm = {{11{instruction_i[31]}}, instruction_i[31], instruction_i[19:12],
                       instruction_i[20], instruction_i[30:21], 1'b0};
            end
            default: op = OP_NOP;
        endcase
    end

    // Ops with a destination register
    assign writes  = !(op inside {OP_NOP, OP_SW, OP_BEQ, OP_BNE});
    // Register second operand only for R-type and compares
    assign use_rs2 = (opcode == OPC_OP) || (opcode == OPC_BRANCH);

    //////////////////////////////////////////////////////////////////////
    // Hazard and issue
    //////////////////////////////////////////////////////////////////////

    // write_o already excludes bubbles and x0
    assign hazard_o = valid_i && write_o && (rd_o == rs1_o || rd_o == rs2_o);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_o <= 1'b0;
            op_o    <= OP_NOP;
            write_o <= 1'b0;
            rd_o    <= '0;
        end
        else if (!stall_i) begin
            if (jump_i || hazard_o || !valid_i) begin
                // Bubble
                valid_o <= 1'b0;
                op_o    <= OP_NOP;
                write_o <= 1'b0;
            end
            else begin
                valid_o <= 1'b1;
                op_o    <= op;
                write_o <= writes && (rd != '0);
                rd_o    <= rd;
            end
        end
    end

    // Operand payload
    always_ff @(posedge clk) begin
        if (!stall_i) begin
            first_operand_o  <= rs1_data_i;
            second_operand_o <= use_rs2 ? rs2_data_i : imm;
            store_data_o     <= rs2_data_i;
            pc_o             <= pc_i;
            imm_o            <= imm;
        end
    end

    // Held instruction comes back unchanged from fetch after a hazard edge
    assert property (@(posedge clk) disable iff (rst_i)
        hazard_o && !stall_i && !jump_i |=>
            valid_i && $stable(instruction_i) && $stable(pc_i))
        else $error("instruction lost during hazard hold");

endmodule

// File: rs5_execute.sv
/* Loads take mem_data_i in the retire cycle, one clock after the request
   Only full-word accesses, the write mask is all-ones or zero */
module rs5_execute (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                stall_i,
    input  rs5_pkg::op_e        op_i,
    input  rs5_pkg::word_t      first_operand_i,
    input  rs5_pkg::word_t      second_operand_i,
    input  rs5_pkg::word_t      store_data_i,
    input  rs5_pkg::word_t      pc_i,
    input  rs5_pkg::word_t      imm_i,
    input  rs5_pkg::reg_addr_t  rd_i,
    input  logic                write_i,
    input  logic                valid_i,
    input  rs5_pkg::word_t      mem_data_i,
    output logic                jump_o,
    output rs5_pkg::word_t      jump_target_o,
    output logic                mem_operation_enable_o,
    output rs5_pkg::byte_en_t   mem_write_enable_o,
    output rs5_pkg::word_t      mem_address_o,
    output rs5_pkg::word_t      mem_data_o,
    output logic                reg_write_o,
    output rs5_pkg::reg_addr_t  reg_rd_o,
    output rs5_pkg::word_t      reg_data_o
);
    import rs5_pkg::*;

    word_t     sum;
    word_t     result;
    logic      equal;
    // Retire stage
    logic      write_q;
    logic      load_q;
    reg_addr_t rd_q;
    word_t     result_q;

    //////////////////////////////////////////////////////////////////////
    // ALU
    //////////////////////////////////////////////////////////////////////

    // Adder shared by ADD, loads and stores
    assign sum   = first_operand_i + second_operand_i;
    assign equal = (first_operand_i == second_operand_i);

    always_comb begin
        case (op_i)
            OP_ADD:  result = sum;
            OP_SUB:  result = first_operand_i - second_operand_i;
            OP_AND:  result = first_operand_i & second_operand_i;
            OP_OR:   result = first_operand_i | second_operand_i;
            OP_XOR:  result = first_operand_i ^ second_operand_i;
            OP_SLT:  result = {31'b0, $signed(first_operand_i) < $signed(second_operand_i)};
            OP_SLTU: result = {31'b0, first_operand_i < second_operand_i};
            OP_SLL:  result = first_operand_i << second_operand_i[4:0];
            OP_SRL:  result = first_operand_i >> second_operand_i[4:0];
            OP_SRA:  result = $signed(first_operand_i) >>> second_operand_i[4:0];
            OP_LUI:  result = second_operand_i;
            OP_LW:   result = sum;
            OP_SW:   result = sum;
            // Link value
            OP_JAL:  result = pc_i + 32'd4;
            default: result = '0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Branches and memory request
    //////////////////////////////////////////////////////////////////////

    assign jump_o = valid_i && ((op_i == OP_BEQ && equal) ||
                                (op_i == OP_BNE && !equal) ||
                                (op_i == OP_JAL));
    assign jump_target_o = pc_i + imm_i;

    assign mem_operation_enable_o = valid_i && (op_i == OP_LW || op_i == OP_SW);
    assign mem_write_enable_o     = (valid_i && op_i == OP_SW) ? 4'hF : 4'h0;
    assign mem_address_o          = sum;
    assign mem_data_o             = store_data_i;

    //////////////////////////////////////////////////////////////////////
    // Retire
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_i) begin
            write_q <= 1'b0;
            load_q  <= 1'b0;
        end
        else if (!stall_i) begin
            write_q <= valid_i && write_i;
            load_q  <= valid_i && op_i == OP_LW;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            rd_q     <= rd_i;
            result_q <= result;
        end
    end

    // Load data arrives during retire
    assign reg_write_o = write_q;
    assign reg_rd_o    = rd_q;
    assign reg_data_o  = load_q ? mem_data_i : result_q;

    // Stalled request repeats unchanged
    assert property (@(posedge clk) disable iff (rst_i)
        stall_i |=> $stable(mem_operation_enable_o) && $stable(mem_write_enable_o) &&
                    $stable(mem_address_o) && $stable(mem_data_o))
        else $error("memory request changed under stall");

endmodule

// File: rs5_core.sv
/* Four-stage in-order RV32I subset core, stall_i freezes every stage
   Both memories answer one clock after an unstalled edge */
module rs5_core (
    input  logic              clk,
    input  logic              rst_i,
    input  logic              stall_i,
    input  rs5_pkg::word_t    instruction_i,
    input  rs5_pkg::word_t    mem_data_i,
    output rs5_pkg::word_t    instruction_address_o,
    output logic              mem_operation_enable_o,
    output rs5_pkg::byte_en_t mem_write_enable_o,
    output rs5_pkg::word_t    mem_address_o,
    output rs5_pkg::word_t    mem_data_o
);
    import rs5_pkg::*;

    // Control between stages
    logic      jump;
    word_t     jump_target;
    logic      hazard;

    // Fetch to decode
    word_t     fetch_instruction;
    word_t     fetch_pc;
    logic      fetch_valid;

    // Register read
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     rs1_data;
    word_t     rs2_data;

    // Decode to execute
    op_e       ex_op;
    word_t     ex_first;
    word_t     ex_second;
    word_t     ex_store_data;
    word_t     ex_pc;
    word_t     ex_imm;
    reg_addr_t ex_rd;
    logic      ex_write;
    logic      ex_valid;

    // Retire write-back
    logic      wb_write;
    reg_addr_t wb_rd;
    word_t     wb_data;

    //////////////////////////////////////////////////////////////////////
    // Front end
    //////////////////////////////////////////////////////////////////////

    rs5_fetch fetch1 (
        .clk                   (clk),
        .rst_i                 (rst_i),
        .stall_i               (stall_i),
        .hazard_i              (hazard),
        .jump_i                (jump),
        .jump_target_i         (jump_target),
        .instruction_i         (instruction_i),
        .instruction_address_o (instruction_address_o),
        .instruction_o         (fetch_instruction),
        .pc_o                  (fetch_pc),
        .valid_o               (fetch_valid)
    );

    rs5_decode decoder1 (
        .clk              (clk),
        .rst_i            (rst_i),
        .stall_i          (stall_i),
        .jump_i           (jump),
        .instruction_i    (fetch_instruction),
        .pc_i             (fetch_pc),
        .valid_i          (fetch_valid),
        .rs1_data_i       (rs1_data),
        .rs2_data_i       (rs2_data),
        .rs1_o            (rs1),
        .rs2_o            (rs2),
        .hazard_o         (hazard),
        .op_o             (ex_op),
        .first_operand_o  (ex_first),
        .second_operand_o (ex_second),
        .store_data_o     (ex_store_data),
        .pc_o             (ex_pc),
        .imm_o            (ex_imm),
        .rd_o             (ex_rd),
        .write_o          (ex_write),
        .valid_o          (ex_valid)
    );

    // Written from retire, read from decode
    rs5_regbank regbank1 (
        .clk     (clk),
        .rst_i   (rst_i),
        .rs1_i   (rs1),
        .rs2_i   (rs2),
        .rd_i    (wb_rd),
        .write_i (wb_write),
        .data_i  (wb_data),
        .data1_o (rs1_data),
        .data2_o (rs2_data)
    );

    //////////////////////////////////////////////////////////////////////
    // Back end
    //////////////////////////////////////////////////////////////////////

    rs5_execute execute1 (
        .clk                    (clk),
        .rst_i                  (rst_i),
        .stall_i                (stall_i),
        .op_i                   (ex_op),
        .first_operand_i        (ex_first),
        .second_operand_i       (ex_second),
        .store_data_i           (ex_store_data),
        .pc_i                   (ex_pc),
        .imm_i                  (ex_imm),
        .rd_i                   (ex_rd),
        .write_i                (ex_write),
        .valid_i                (ex_valid),
        .mem_data_i             (mem_data_i),
        .jump_o                 (jump),
        .jump_target_o          (jump_target),
        .mem_operation_enable_o (mem_operation_enable_o),
        .mem_write_enable_o     (mem_write_enable_o),
        .mem_address_o          (mem_address_o),
        .mem_data_o             (mem_data_o),
        .reg_write_o            (wb_write),
        .reg_rd_o               (wb_rd),
        .reg_data_o             (wb_data)
    );

endmodule

// File: tb_rs5.sv
/* Program and expected stores come from rs5_patterns.txt
   Only the order of stores is checked, never their cycle. Random stall is about 25 percent */
module tb_rs5;
    timeunit 1ns;
    timeprecision 1ps;

    import rs5_pkg::*;

    localparam int MEM_WORDS = 256;
    localparam int TIMEOUT   = 2000;

    logic     clk;
    logic     rst_i;
    logic     stall_i;
    word_t    instruction_i;
    word_t    mem_data_i;
    word_t    instruction_address_o;
    logic     mem_operation_enable_o;
    byte_en_t mem_write_enable_o;
    word_t    mem_address_o;
    word_t    mem_data_o;

    // Memory models
    word_t imem [0:MEM_WORDS-1];
    word_t dmem [0:MEM_WORDS-1];

    // Expected ordered store list
    word_t exp_addr [$];
    word_t exp_data [$];

    int       stores_seen;
    int       value_errors;
    int       other_errors;
    int       seed;
    logic     running;

    rs5_core UUT (
        .clk                    (clk),
        .rst_i                  (rst_i),
        .stall_i                (stall_i),
        .instruction_i          (instruction_i),
        .mem_data_i             (mem_data_i),
        .instruction_address_o  (instruction_address_o),
        .mem_operation_enable_o (mem_operation_enable_o),
        .mem_write_enable_o     (mem_write_enable_o),
        .mem_address_o          (mem_address_o),
        .mem_data_o             (mem_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Memories frozen under stall
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (!stall_i)
            instruction_i <= imem[instruction_address_o[9:2]];
    end

    // Store check and write with the load answer one cycle later
    always @(posedge clk) begin
        if (!rst_i && !stall_i && mem_operation_enable_o) begin
            if (mem_write_enable_o == 4'hF) begin
                dmem[mem_address_o[9:2]] <= mem_data_o;
                if (stores_seen >= exp_addr.size()) begin
                    $display("Unexpected extra store to address %h with data %h",
                             mem_address_o, mem_data_o);
                    other_errors++;
                end
                else begin
                    if (mem_address_o != exp_addr[stores_seen]) begin
                        $display("[FAIL] mem_address_o: got %h expected %h (store %0d)",
                                 mem_address_o, exp_addr[stores_seen], stores_seen);
                        value_errors++;
                    end
                    if (mem_data_o != exp_data[stores_seen]) begin
                        $display("[FAIL] mem_data_o: got %h expected %h (store %0d)",
                                 mem_data_o, exp_data[stores_seen], stores_seen);
                        value_errors++;
                    end
                end
                stores_seen++;
            end
            else if (mem_write_enable_o == 4'h0) begin
                mem_data_i <= dmem[mem_address_o[9:2]];
            end
            else begin
                $display("Partial write mask %h seen on a word-only core",
                         mem_write_enable_o);
                other_errors++;
            end
        end
    end

    // Random back-pressure once the run starts
    always @(posedge clk) begin
        if (running)
            stall_i <= (($random(seed) & 32'd3) == 32'd0);
        else
            stall_i <= 1'b0;
    end

    //////////////////////////////////////////////////////////////////////
    // Pattern file
    //////////////////////////////////////////////////////////////////////

    task automatic read_patterns();
        int               fd;
        int               code;
        logic [8*8-1:0]   tag;
        logic [8*200-1:0] rest;
        word_t            addr;
        word_t            data;
        fd = $fopen("rs5_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open the pattern file rs5_patterns.txt");
            other_errors++;
            return;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", tag);
            if (code != 1)
                break;
            if (tag == "#") begin
                code = $fgets(rest, fd);
            end
            else begin
                code = $fscanf(fd, "%h %h", addr, data);
                if (code != 2) begin
                    $display("Malformed pattern line after tag %0s", tag);
                    other_errors++;
                end
                else if (tag == "I") begin
                    imem[addr[9:2]] = data;
                end
                else if (tag == "S") begin
                    exp_addr.push_back(addr);
                    exp_data.push_back(data);
                end
                else begin
                    $display("Unknown pattern tag %0s", tag);
                    other_errors++;
                end
            end
        end
        $fclose(fd);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int cycles;
        rst_i         = 1'b1;
        stall_i       = 1'b0;
        instruction_i = '0;
        mem_data_i    = '0;
        running       = 1'b0;
        stores_seen   = 0;
        value_errors  = 0;
        other_errors  = 0;
        seed          = 32'h5bc51121;

        // Empty slots read as NOP
        // Data words carry their own address
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = '0;
            dmem[i] = 32'hA500_0000 ^ (i << 2);
        end
        read_patterns();

        repeat (2) @(posedge clk);
        rst_i <= 1'b0;
        #1;

        // Reset state
        if (instruction_address_o != RESET_ADDR) begin
            $display("[FAIL] instruction_address_o: got %h expected %h",
                     instruction_address_o, RESET_ADDR);
            value_errors++;
        end
        if (mem_operation_enable_o != 1'b0) begin
            $display("[FAIL] mem_operation_enable_o: got %h expected %h",
                     mem_operation_enable_o, 1'b0);
            value_errors++;
        end

        running = 1'b1;

        // Wait for the last expected store
        cycles = 0;
        while (stores_seen < exp_addr.size() && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (stores_seen < exp_addr.size()) begin
            $display("Timeout after %0d cycles, only %0d of %0d stores seen",
                     TIMEOUT, stores_seen, exp_addr.size());
            other_errors++;
        end

        // Drain so that any stray store is caught
        repeat (40) @(posedge clk);
        #1;

        $display("Errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Result: PASSED");
        end
        else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: rs5_patterns.txt
# Columns: tag address data, all hex
# I = program word at address, S = expected store in order
I 00000000 123450B7
I 00000004 FFB00113
I 00000008 00300193
I 0000000C 00208233
I 00000010 10402023
I 00000014 402182B3
I 00000018 00312333
I 0000001C 003133B3
I 00000020 40315433
I 00000024 003154B3
I 00000028 00319533
I 0000002C 0020C5B3
I 00000030 0011E633
I 00000034 001176B3
I 00000038 0FF17713
I 0000003C 40115793
I 00000040 10502223
I 00000044 10602423
I 00000048 10702623
I 0000004C 10802823
I 00000050 10902A23
I 00000054 10A02C23
I 00000058 10B02E23
I 0000005C 12C02023
I 00000060 12D02223
I 00000064 12E02423
I 00000068 12F02623
I 0000006C 10002803
I 00000070 13002823
I 00000074 00318463
I 00000078 1E002823
I 0000007C 00319463
I 00000080 12302A23
I 00000084 008008EF
I 00000088 1E002A23
I 0000008C 13102C23
I 00000090 0000006F
# add, sub, slt, sltu, sra, srl, sll, xor, or, and, andi, srai
S 00000100 12344FFB
S 00000104 00000008
S 00000108 00000001
S 0000010C 00000000
S 00000110 FFFFFFFF
S 00000114 1FFFFFFF
S 00000118 00000018
S 0000011C EDCBAFFB
S 00000120 12345003
S 00000124 12345000
S 00000128 000000FB
S 0000012C FFFFFFFD
# load after store, untaken bne, jal link
S 00000130 12344FFB
S 00000134 00000003
S 00000138 00000088

// File: all.f
rs5_pkg.sv
rs5_regbank.sv
rs5_fetch.sv
rs5_decode.sv
rs5_execute.sv
rs5_core.sv
tb_rs5.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_rs5 -f all.f -o sim_rs5

./obj_dir/sim_rs5 | tee sim.log

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
exit 0
